// File: cpu_pkg.sv
package cpu_pkg;

    // architectural addresses.
    localparam logic [31:0] RESET_PC   = 32'h8000_0000;
    localparam logic [31:0] EXC_VECTOR = 32'h8000_0380;
    localparam logic [31:0] PC_STEP    = 32'd4;

    // one hold bit per stage register.
    // pc sits in bit 0, wb in bit 5.
    typedef struct packed {
        logic wb;
        logic mem_wb;
        logic ex_mem;
        logic id_ex;
        logic if_id;
        logic pc;
    } stall_t;

    // exception flags of the instruction in the memory stage.
    typedef struct packed {
        logic interrupt;
        logic syscall;
        logic reserved_inst;
        logic trap;
        logic overflow;
        logic eret;
        logic break_req;
    } mem_exc_t;

    // values follow the cause register codes.
    typedef enum logic [31:0] {
        exc_none    = 32'd0,
        exc_int     = 32'd1,
        exc_syscall = 32'd8,
        exc_ri      = 32'd10,
        exc_ov      = 32'd12,
        exc_trap    = 32'd13,
        exc_eret    = 32'd14,
        exc_break   = 32'd15
    } excode_t;

    typedef enum logic [2:0] {
        sel_run,
        sel_except,
        sel_ex_stall,
        sel_id_stall,
        sel_store_hold,
        sel_store_commit,
        sel_mem_stall
    } ctrl_sel_e;

endpackage

// File: except_cause.sv
`timescale 1ns/1ps

module except_cause (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  cpu_pkg::mem_exc_t    mem_exc_i,
    input  logic [31:0]          mem_pc_i,
    input  logic                 flush_i,
    output cpu_pkg::excode_t     excode_o,
    output logic [31:0]          redirect_pc_o
);

    logic [31:0] epc_q;

    // highest raised flag wins.
    always_comb begin
        if (mem_exc_i.interrupt) begin
            excode_o = cpu_pkg::exc_int;
        end else if (mem_exc_i.syscall) begin
            excode_o = cpu_pkg::exc_syscall;
        end else if (mem_exc_i.reserved_inst) begin
            excode_o = cpu_pkg::exc_ri;
        end else if (mem_exc_i.trap) begin
            excode_o = cpu_pkg::exc_trap;
        end else if (mem_exc_i.overflow) begin
            excode_o = cpu_pkg::exc_ov;
        end else if (mem_exc_i.eret) begin
            excode_o = cpu_pkg::exc_eret;
        end else if (mem_exc_i.break_req) begin
            excode_o = cpu_pkg::exc_break;
        end else begin
            excode_o = cpu_pkg::exc_none;
        end
    end

    // eret returns to the saved pc.
    always_comb begin
        if (excode_o == cpu_pkg::exc_eret) begin
            redirect_pc_o = epc_q;
        end else begin
            redirect_pc_o = cpu_pkg::EXC_VECTOR;
        end
    end

    // epc of the faulting instruction.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            epc_q <= 32'd0;
        end else if (flush_i && excode_o != cpu_pkg::exc_eret) begin
            epc_q <= mem_pc_i;
        end
    end

endmodule

// File: pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stallreq_id_i,
    input  logic                 stallreq_ex_i,
    input  logic                 stallreq_mem_i,
    input  logic                 mem_we_i,
    input  cpu_pkg::excode_t     excode_i,
    input  logic [31:0]          redirect_pc_i,
    output cpu_pkg::stall_t      stall_o,
    output logic                 flush_o,
    output logic                 mem_we_o,
    output logic [31:0]          new_pc_o
);

    cpu_pkg::ctrl_sel_e sel;
    logic               pause_q;

    // decision for this cycle, highest priority first.
    always_comb begin
        if (excode_i != cpu_pkg::exc_none) begin
            sel = cpu_pkg::sel_except;
        end else if (stallreq_ex_i) begin
            sel = cpu_pkg::sel_ex_stall;
        end else if (stallreq_id_i) begin
            sel = cpu_pkg::sel_id_stall;
        end else if (mem_we_i && !pause_q) begin
            sel = cpu_pkg::sel_store_hold;
        end else if (mem_we_i && pause_q) begin
            sel = cpu_pkg::sel_store_commit;
        end else if (stallreq_mem_i) begin
            sel = cpu_pkg::sel_mem_stall;
        end else begin
            sel = cpu_pkg::sel_run;
        end
    end

    always_comb begin
        stall_o  = '0;
        flush_o  = 1'b0;
        mem_we_o = 1'b0;
        new_pc_o = 32'd0;
        case (sel)
            cpu_pkg::sel_except: begin
                flush_o  = 1'b1;
                new_pc_o = redirect_pc_i;
            end
            cpu_pkg::sel_ex_stall: begin
                stall_o.pc     = 1'b1;
                stall_o.if_id  = 1'b1;
                stall_o.id_ex  = 1'b1;
                stall_o.ex_mem = 1'b1;
            end
            cpu_pkg::sel_id_stall: begin
                stall_o.pc    = 1'b1;
                stall_o.if_id = 1'b1;
                stall_o.id_ex = 1'b1;
            end
            // first phase, memory write held back.
            cpu_pkg::sel_store_hold: begin
                stall_o.pc     = 1'b1;
                stall_o.if_id  = 1'b1;
                stall_o.id_ex  = 1'b1;
                stall_o.ex_mem = 1'b1;
                stall_o.mem_wb = 1'b1;
            end
            // second phase, the store reaches memory.
            cpu_pkg::sel_store_commit: begin
                stall_o.pc     = 1'b1;
                stall_o.if_id  = 1'b1;
                stall_o.id_ex  = 1'b1;
                stall_o.ex_mem = 1'b1;
                mem_we_o       = 1'b1;
            end
            cpu_pkg::sel_mem_stall: begin
                stall_o.pc    = 1'b1;
                stall_o.if_id = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // store pause phase.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pause_q <= 1'b0;
        end else if (flush_o) begin
            pause_q <= 1'b0;
        end else if (sel == cpu_pkg::sel_store_hold || sel == cpu_pkg::sel_store_commit) begin
            pause_q <= ~pause_q;
        end
    end

endmodule

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_pc_i,
    input  logic        flush_i,
    input  logic [31:0] new_pc_i,
    output logic [31:0] pc_o
);

    // flush beats the stall hold.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= cpu_pkg::RESET_PC;
        end else if (flush_i) begin
            pc_o <= new_pc_i;
        end else if (!stall_pc_i) begin
            pc_o <= pc_o + cpu_pkg::PC_STEP;
        end
    end

endmodule

// File: pipe_ctrl_top.sv
`timescale 1ns/1ps

module pipe_ctrl_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stallreq_id_i,
    input  logic                 stallreq_ex_i,
    input  logic                 stallreq_mem_i,
    input  logic                 mem_we_i,
    input  cpu_pkg::mem_exc_t    mem_exc_i,
    input  logic [31:0]          mem_pc_i,
    output cpu_pkg::stall_t      stall_o,
    output logic                 flush_o,
    output logic                 mem_we_o,
    output logic [31:0]          new_pc_o,
    output cpu_pkg::excode_t     excode_o,
    output logic [31:0]          pc_o
);

    cpu_pkg::excode_t excode;
    cpu_pkg::stall_t  stall;
    logic [31:0]      redirect_pc;
    logic [31:0]      new_pc;
    logic             flush;

    except_cause u_except_cause (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_exc_i     (mem_exc_i),
        .mem_pc_i      (mem_pc_i),
        .flush_i       (flush),
        .excode_o      (excode),
        .redirect_pc_o (redirect_pc)
    );

    pipe_ctrl u_pipe_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stallreq_id_i  (stallreq_id_i),
        .stallreq_ex_i  (stallreq_ex_i),
        .stallreq_mem_i (stallreq_mem_i),
        .mem_we_i       (mem_we_i),
        .excode_i       (excode),
        .redirect_pc_i  (redirect_pc),
        .stall_o        (stall),
        .flush_o        (flush),
        .mem_we_o       (mem_we_o),
        .new_pc_o       (new_pc)
    );

    // fetch pc follows the pc hold bit.
    pc_gen u_pc_gen (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_pc_i (stall.pc),
        .flush_i    (flush),
        .new_pc_i   (new_pc),
        .pc_o       (pc_o)
    );

    assign stall_o  = stall;
    assign flush_o  = flush;
    assign new_pc_o = new_pc;
    assign excode_o = excode;

endmodule

// File: pipe_ctrl_props.sv
`timescale 1ns/1ps

module pipe_ctrl_props (
    input logic            clk,
    input logic            rst_n_i,
    input cpu_pkg::stall_t stall_o,
    input logic            flush_o,
    input logic            mem_we_i,
    input logic            mem_we_o,
    input logic [31:0]     new_pc_o
);

    logic [5:0] stall_vec;

    assign stall_vec = stall_o;

    a_flush_no_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_o |-> stall_vec == 6'd0)
        else $error("flush_o raised while stall bits are set");

    // held stages form a run that starts at the pc.
    a_stall_contiguous: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_vec & (stall_vec + 6'd1)) == 6'd0)
        else $error("stall vector is not a contiguous run from bit pc");

    a_store_gated: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_we_o |-> mem_we_i)
        else $error("mem_we_o raised without mem_we_i");

    a_new_pc_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !flush_o |-> new_pc_o == 32'd0)
        else $error("new_pc_o is not zero while flush_o is low");

endmodule

bind pipe_ctrl_top pipe_ctrl_props u_pipe_ctrl_props (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .stall_o  (stall_o),
    .flush_o  (flush_o),
    .mem_we_i (mem_we_i),
    .mem_we_o (mem_we_o),
    .new_pc_o (new_pc_o)
);

// File: tb_pipe_ctrl.sv
`timescale 1ns/1ps

module tb_pipe_ctrl;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 300;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD + 200;

    // expected outputs and the model state for the next cycle.
    typedef struct packed {
        cpu_pkg::stall_t  stall;
        logic             flush;
        logic             we;
        logic [31:0]      new_pc;
        cpu_pkg::excode_t code;
        logic [31:0]      next_pc;
        logic             next_pause;
        logic [31:0]      next_epc;
    } expect_t;

    logic               clk;
    logic               rst_n_i;
    logic               stallreq_id_i;
    logic               stallreq_ex_i;
    logic               stallreq_mem_i;
    logic               mem_we_i;
    cpu_pkg::mem_exc_t  mem_exc_i;
    logic [31:0]        mem_pc_i;
    cpu_pkg::stall_t    stall_o;
    logic               flush_o;
    logic               mem_we_o;
    logic [31:0]        new_pc_o;
    cpu_pkg::excode_t   excode_o;
    logic [31:0]        pc_o;

    logic               check_en;
    string              test_name;
    logic               m_pause;
    logic [31:0]        m_epc;
    logic [31:0]        m_pc;
    integer             seed;

    pipe_ctrl_top u_pipe_ctrl_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stallreq_id_i  (stallreq_id_i),
        .stallreq_ex_i  (stallreq_ex_i),
        .stallreq_mem_i (stallreq_mem_i),
        .mem_we_i       (mem_we_i),
        .mem_exc_i      (mem_exc_i),
        .mem_pc_i       (mem_pc_i),
        .stall_o        (stall_o),
        .flush_o        (flush_o),
        .mem_we_o       (mem_we_o),
        .new_pc_o       (new_pc_o),
        .excode_o       (excode_o),
        .pc_o           (pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_stall(input string sig, input cpu_pkg::stall_t exp,
                               input cpu_pkg::stall_t act);
        if (act !== exp) begin
            $display("ERR test=%s %s expected=%b actual=%b", test_name, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR test=%s %s expected=%b actual=%b", test_name, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR test=%s %s expected=%h actual=%h", test_name, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_code(input string sig, input cpu_pkg::excode_t exp,
                              input cpu_pkg::excode_t act);
        if (act !== exp) begin
            $display("ERR test=%s %s expected=%s actual=%0d", test_name, sig, exp.name(), act);
            abort_run();
        end
    endtask

    // flag bit index to cause code, bit 0 is break_req.
    function automatic cpu_pkg::excode_t flag_code(input int idx);
        case (idx)
            0:       return cpu_pkg::exc_break;
            1:       return cpu_pkg::exc_eret;
            2:       return cpu_pkg::exc_ov;
            3:       return cpu_pkg::exc_trap;
            4:       return cpu_pkg::exc_ri;
            5:       return cpu_pkg::exc_syscall;
            6:       return cpu_pkg::exc_int;
            default: return cpu_pkg::exc_none;
        endcase
    endfunction

    function automatic expect_t model_ctrl(
        input logic id, input logic ex, input logic mem, input logic we,
        input cpu_pkg::mem_exc_t exc, input logic [31:0] mpc,
        input logic pause, input logic [31:0] epc, input logic [31:0] pc);
        expect_t    res;
        logic [6:0] flags;
        logic       store;
        int         depth;
        int         b;
        res   = '0;
        flags = exc;
        // later bits overwrite, so the highest raised flag wins.
        for (b = 0; b < 7; b++) begin
            if (flags[b]) begin
                res.code = flag_code(b);
            end
        end
        res.flush = (res.code != cpu_pkg::exc_none);
        store = we && !res.flush && !ex && !id;
        depth = res.flush ? 0 :
                ex        ? 4 :
                id        ? 3 :
                store     ? (pause ? 4 : 5) :
                mem       ? 2 : 0;
        res.stall = cpu_pkg::stall_t'(6'((1 << depth) - 1));
        res.we = store && pause;
        if (res.flush) begin
            res.new_pc = (res.code == cpu_pkg::exc_eret) ? epc : cpu_pkg::EXC_VECTOR;
        end
        res.next_pause = res.flush ? 1'b0 : (store ? ~pause : pause);
        res.next_epc = (res.flush && res.code != cpu_pkg::exc_eret) ? mpc : epc;
        res.next_pc = res.flush ? res.new_pc : (res.stall.pc ? pc : pc + cpu_pkg::PC_STEP);
        return res;
    endfunction

    task automatic apply_cycle(input logic id, input logic ex, input logic mem, input logic we,
                               input cpu_pkg::mem_exc_t exc, input logic [31:0] mpc);
        stallreq_id_i  = id;
        stallreq_ex_i  = ex;
        stallreq_mem_i = mem;
        mem_we_i       = we;
        mem_exc_i      = exc;
        mem_pc_i       = mpc;
        @(posedge clk);
        #1;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0, 32'd0);
    endtask

    // sample one ns before each rising edge.
    initial begin : compare_outputs
        expect_t want;
        forever begin
            @(posedge clk);
            #3;
            if (check_en) begin
                want = model_ctrl(stallreq_id_i, stallreq_ex_i, stallreq_mem_i, mem_we_i,
                                  mem_exc_i, mem_pc_i, m_pause, m_epc, m_pc);
                check_word("pc_o", m_pc, pc_o);
                check_stall("stall_o", want.stall, stall_o);
                check_bit("flush_o", want.flush, flush_o);
                check_bit("mem_we_o", want.we, mem_we_o);
                check_word("new_pc_o", want.new_pc, new_pc_o);
                check_code("excode_o", want.code, excode_o);
                m_pause = want.next_pause;
                m_epc   = want.next_epc;
                m_pc    = want.next_pc;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] rpc;
        int          c;
        int          i;
        seed           = 32'h34e8_ba28;
        check_en       = 1'b0;
        test_name      = "reset";
        m_pause        = 1'b0;
        m_epc          = 32'd0;
        m_pc           = cpu_pkg::RESET_PC;
        rst_n_i        = 1'b0;
        stallreq_id_i  = 1'b0;
        stallreq_ex_i  = 1'b0;
        stallreq_mem_i = 1'b0;
        mem_we_i       = 1'b0;
        mem_exc_i      = '0;
        mem_pc_i       = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i  = 1'b1;
        check_en = 1'b1;

        test_name = "reset_run";
        run_cycles(8);

        test_name = "stall_priority";
        for (c = 0; c < 8; c++) begin
            apply_cycle(c[0], c[1], c[2], 1'b0, '0, 32'd0);
            apply_cycle(c[0], c[1], c[2], 1'b0, '0, 32'd0);
        end
        run_cycles(1);

        test_name = "store_two_phase";
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, 32'h0040_0020);
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, 32'h0040_0020);
        run_cycles(1);

        // trap in phase two, store starts over.
        test_name = "store_restart";
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, 32'h0040_0040);
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, cpu_pkg::mem_exc_t'(7'b000_1000), 32'h0040_0044);
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, 32'h0040_0048);
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, 32'h0040_0048);
        run_cycles(1);

        test_name = "store_behind_stall";
        apply_cycle(1'b0, 1'b1, 1'b0, 1'b1, '0, 32'd0);
        apply_cycle(1'b1, 1'b0, 1'b1, 1'b1, '0, 32'd0);
        apply_cycle(1'b0, 1'b0, 1'b1, 1'b1, '0, 32'd0);
        apply_cycle(1'b0, 1'b0, 1'b1, 1'b1, '0, 32'd0);
        run_cycles(1);

        test_name = "exc_single";
        for (c = 0; c < 7; c++) begin
            apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::mem_exc_t'(7'(1 << c)),
                        32'h0040_1000 + 32'(c * 4));
            // bit 1 is eret and returns to the epc.
            if (c != 1) begin
                check_word("pc_o at vector", cpu_pkg::EXC_VECTOR, pc_o);
            end
            run_cycles(1);
        end

        test_name = "exc_combined";
        for (c = 1; c < 128; c++) begin
            apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::mem_exc_t'(7'(c)),
                        32'h0040_2000 + 32'(c * 4));
        end

        test_name = "eret_return";
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::mem_exc_t'(7'b010_0000), 32'h0040_2a10);
        run_cycles(3);
        apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, cpu_pkg::mem_exc_t'(7'b000_0010), 32'h0040_3000);
        check_word("pc_o after eret", 32'h0040_2a10, pc_o);
        run_cycles(2);

        // sparse flags so that plain cycles and stores still occur.
        test_name = "random";
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            r   = $random(seed);
            rpc = $random(seed);
            apply_cycle(r[0] & r[1], r[2] & r[3], r[4], r[5],
                        cpu_pkg::mem_exc_t'(r[12:6] & r[19:13] & r[26:20]), rpc);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: vlog.f
cpu_pkg.sv
except_cause.sv
pipe_ctrl.sv
pc_gen.sv
pipe_ctrl_top.sv
pipe_ctrl_props.sv
tb_pipe_ctrl.sv

// File: run.sh
#!/bin/sh
# compile and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_pipe_ctrl -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1
